/* all.f */
+incdir+include
hdl/neoVideoPkg.sv
hdl/lineBuffer.sv
hdl/paletteAddrMux.sv
hdl/hostBusPort.sv
hdl/pixelMixer.sv
test/pixelMixerTb.sv

/* run.sh */
#!/bin/sh
# Build and run the pixel mixer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module pixelMixerTb -o pixelMixerSim

# The log decides the result, a fatal stop still leaves it behind
./obj_dir/pixelMixerSim > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
	echo "Simulation reported a failure"
	exit 1
fi
if ! grep -q "TEST RESULT: PASS" sim.log; then
	echo "Simulation ended without a result"
	exit 1
fi
exit 0

/* test/pixelMixerTb.sv */
//*********************************************************************
// Pixel mixer testbench
// Line table with reference buffers, host bus and watchdog checks
//*********************************************************************

`timescale 1ns/1ns

`include "pixelMixer_cfg.svh"

module pixelMixerTb import neoVideoPkg::*; ();

	// Host operation after the pixels of a line
	localparam int opNone      = 0;
	localparam int opPalRead   = 1;
	localparam int opPalWrite  = 2;
	localparam int opKickRead  = 3;
	localparam int opOtherRead = 4;
	localparam int lineCount   = 7;

	typedef struct {
		logic    sel;
		int      drawStart;
		int      showStart;
		int      numPix;
		// Opaque fix pixel every n pixels
		// Zero means no fix pixel
		int      fixEvery;
		// Blank over pixel indices blankFrom up to blankTo
		int      blankFrom;
		int      blankTo;
		int      hostOp;
		wbAddr_t hostAdr;
	} lineStep_t;

	logic         CLK_1HB;
	logic         reset;
	logic         lineSel, drawLoad, drawStep, showLoad, showStep, hblank;
	lbAddr_t      drawStart, showStart;
	pixelColor_t  spriteColor, fixColor;
	spritePal_t   spritePal;
	fixPal_t      fixPal;
	logic         wbCyc, wbStb, wbWe, wbAck, cpuReset;
	wbAddr_t      wbAdr;
	wbData_t      wbDatW, wbDatR;
	paletteAddr_t paletteAddr;

	// Reference copy of both buffers
	// Index 0 is buffer A
	paletteAddr_t refBuf [2][1 << `LB_ADDR_BITS];
	lineStep_t    lineTable [lineCount];
	logic [31:0]  lcgState;
	int           cycleCount = 0;
	int           cycleLimit;
	int           edgeIdx;
	int           lastKick;
	// Expected video output two edges behind the drive
	logic         pipeValid [3];
	paletteAddr_t pipeExp [3];

	pixelMixer DUT (
		.CLK_1HB(CLK_1HB), .reset(reset), .lineSel(lineSel), .drawLoad(drawLoad),
		.drawStart(drawStart), .drawStep(drawStep), .spriteColor(spriteColor),
		.spritePal(spritePal), .showLoad(showLoad), .showStart(showStart),
		.showStep(showStep), .fixColor(fixColor), .fixPal(fixPal), .hblank(hblank),
		.wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr), .wbDatW(wbDatW),
		.wbAck(wbAck), .wbDatR(wbDatR), .paletteAddr(paletteAddr), .cpuReset(cpuReset)
	);

	always #50 CLK_1HB = ~CLK_1HB;

	function automatic logic [31:0] lcgNext();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	task automatic failNow(input string msg);
		$display("%s", msg);
		$display("TEST RESULT: FAIL");
		$fatal(1, "Stopped at the first error");
	endtask

	task automatic checkPaletteAddr(input paletteAddr_t actual, input paletteAddr_t expected,
		input string what);
		if (actual !== expected) begin
			failNow($sformatf("ERROR at %0t ns: %s paletteAddr %03h, expected %03h",
				$time, what, actual, expected));
		end
	endtask

	task automatic checkBusRead(input wbData_t actual, input wbData_t expected);
		if (actual !== expected) begin
			failNow($sformatf("ERROR at %0t ns: wbDatR %04h, expected %04h",
				$time, actual, expected));
		end
	endtask

	task automatic checkReset(input logic actual, input logic expected);
		if (actual !== expected) begin
			failNow($sformatf("ERROR at %0t ns: cpuReset %0b, expected %0b",
				$time, actual, expected));
		end
	endtask

	task automatic checkAck(input logic expected);
		if (wbAck !== expected) begin
			failNow($sformatf("ERROR at %0t ns: wbAck %0b, expected %0b",
				$time, wbAck, expected));
		end
	endtask

	// Waits for a rising edge and notes its index
	task automatic nextEdge();
		@(posedge CLK_1HB);
		edgeIdx = cycleCount;
	endtask

	// Checks at the falling edge the pixel driven two edges earlier
	task automatic settle(input logic valid, input paletteAddr_t expected);
		pipeValid[2] = pipeValid[1];
		pipeValid[1] = pipeValid[0];
		pipeValid[0] = valid;
		pipeExp[2] = pipeExp[1];
		pipeExp[1] = pipeExp[0];
		pipeExp[0] = expected;
		@(negedge CLK_1HB);
		if (pipeValid[2]) begin
			checkPaletteAddr(paletteAddr, pipeExp[2], "video");
		end
	endtask

	// One Wishbone classic access
	// Ack due one edge after the request
	task automatic busAccess(input logic we, input wbAddr_t adr, input wbData_t dat);
		int      reqEdge;
		logic    kickHit;
		wbData_t expData;
		nextEdge();
		reqEdge = edgeIdx;
		kickHit = (adr == `WDOG_KICK_ADDR);
		// Counter value seen at the request edge is reqEdge - lastKick - 1
		expData = (kickHit && !we) ?
			wbData_t'(`WDOG_TIMEOUT - (reqEdge - lastKick - 1)) : wbData_t'(0);
		wbCyc  <= 1'b1;
		wbStb  <= 1'b1;
		wbWe   <= we;
		wbAdr  <= adr;
		wbDatW <= dat;
		settle(1'b0, '0);
		checkAck(1'b0);
		nextEdge();
		settle(1'b0, '0);
		checkAck(1'b1);
		if (adr[15:12] == `PAL_WIN_BASE) begin
			checkPaletteAddr(paletteAddr, adr[11:0], "window");
		end else begin
			// Outside the window the blanked video address stays on the bus
			checkPaletteAddr(paletteAddr, '0, "idle video");
		end
		if (!we) begin
			checkBusRead(wbDatR, expData);
		end
		if (we && kickHit) begin
			lastKick = reqEdge;
		end
		nextEdge();
		wbCyc <= 1'b0;
		wbStb <= 1'b0;
		wbWe  <= 1'b0;
		settle(1'b0, '0);
		checkAck(1'b0);
	endtask

	// Draws one buffer and shows the other before the host accesses
	task automatic applyLine(input int idx);
		lineStep_t    ln;
		int           i;
		int           drawBuf;
		int           showBuf;
		lbAddr_t      dAddr;
		lbAddr_t      sAddr;
		logic [31:0]  rnd;
		pixelColor_t  col;
		spritePal_t   pal;
		pixelColor_t  fc;
		fixPal_t      fp;
		logic         blank;
		paletteAddr_t sp;
		ln = lineTable[idx];
		drawBuf = ln.sel ? 0 : 1;
		showBuf = ln.sel ? 1 : 0;
		dAddr = lbAddr_t'(ln.drawStart);
		sAddr = lbAddr_t'(ln.showStart);
		nextEdge();
		lineSel   <= ln.sel;
		drawLoad  <= 1'b1;
		showLoad  <= 1'b1;
		drawStart <= dAddr;
		showStart <= sAddr;
		settle(1'b0, '0);
		for (i = 0; i < ln.numPix; i++) begin
			rnd = lcgNext();
			col = (rnd[3:2] == 2'b00) ? 4'h0 : rnd[19:16];
			pal = rnd[31:24];
			fc = (ln.fixEvery != 0 && (i % ln.fixEvery) == 0) ? {rnd[11:9], 1'b1} : 4'h0;
			fp = rnd[15:12];
			blank = (i >= ln.blankFrom) && (i < ln.blankTo);
			nextEdge();
			drawLoad    <= 1'b0;
			showLoad    <= 1'b0;
			drawStep    <= 1'b1;
			showStep    <= 1'b1;
			spriteColor <= col;
			spritePal   <= pal;
			fixColor    <= fc;
			fixPal      <= fp;
			hblank      <= blank;
			// Transparent sprite pixels leave the entry alone
			if (col != 4'h0) begin
				refBuf[drawBuf][dAddr] = {pal, col};
			end
			sp = refBuf[showBuf][sAddr];
			refBuf[showBuf][sAddr] = '0;
			dAddr = dAddr + lbAddr_t'(1);
			sAddr = sAddr + lbAddr_t'(1);
			settle(1'b1, blank ? 12'h000 : ((fc != 4'h0) ? {4'h0, fp, fc} : sp));
		end
		// Idle with blank while the last pixels drain
		repeat (3) begin
			nextEdge();
			drawStep <= 1'b0;
			showStep <= 1'b0;
			fixColor <= 4'h0;
			hblank   <= 1'b1;
			settle(1'b0, '0);
		end
		case (ln.hostOp)
			opPalRead, opKickRead, opOtherRead: busAccess(1'b0, ln.hostAdr, 16'h0000);
			opPalWrite: busAccess(1'b1, ln.hostAdr, 16'h0F0F);
			default: ;
		endcase
		busAccess(1'b1, `WDOG_KICK_ADDR, 16'h0001);
		checkReset(cpuReset, 1'b0);
	endtask

	// Last kick followed by the timeout and the reset pulse
	task automatic watchdogRun();
		int fireEdge;
		busAccess(1'b1, `WDOG_KICK_ADDR, 16'h0001);
		fireEdge = lastKick + 1 + `WDOG_TIMEOUT;
		while (edgeIdx < fireEdge + `WDOG_RESET_LEN + 4) begin
			nextEdge();
			settle(1'b0, '0);
			checkReset(cpuReset, (edgeIdx >= fireEdge) &&
				(edgeIdx < fireEdge + `WDOG_RESET_LEN));
		end
	endtask

	function automatic int testLength();
		int total;
		int k;
		total = 11;
		// Load, pixels, drain and two host accesses per line
		for (k = 0; k < lineCount; k++) begin
			total += lineTable[k].numPix + 10;
		end
		total += 3 + `WDOG_TIMEOUT + `WDOG_RESET_LEN + 5;
		return total;
	endfunction

	always @(posedge CLK_1HB) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit) begin
			failNow($sformatf("Timeout: the run did not finish within %0d cycles", cycleLimit));
		end
	end

	initial begin : mainFlow
		int b;
		int a;
		int k;
		CLK_1HB = 1'b0;
		reset = 1'b1;
		{lineSel, drawLoad, drawStep, showLoad, showStep} = '0;
		hblank = 1'b1;
		{drawStart, showStart, spriteColor, spritePal, fixColor, fixPal} = '0;
		{wbCyc, wbStb, wbWe, wbAdr, wbDatW} = '0;
		lcgState = 32'hc6792097;
		lastKick = 0;
		edgeIdx = 0;
		for (b = 0; b < 2; b++) begin
			for (a = 0; a < (1 << `LB_ADDR_BITS); a++) begin
				refBuf[b][a] = '0;
			end
		end
		for (k = 0; k < 3; k++) begin
			pipeValid[k] = 1'b0;
			pipeExp[k] = '0;
		end
		// Two blanked full passes clear both buffers first
		lineTable[0] = '{1'b0, 'h00, 'h00, 256, 0, 0, 256, opNone, 16'h0000};
		lineTable[1] = '{1'b1, 'h10, 'h00, 256, 0, 0, 256, opPalRead, 16'h4123};
		lineTable[2] = '{1'b0, 'h40, 'h10, 24, 0, 0, 0, opKickRead, `WDOG_KICK_ADDR};
		// Same addresses again now cleared by the previous read
		lineTable[3] = '{1'b0, 'h48, 'h10, 24, 0, 0, 0, opPalWrite, 16'h4FFE};
		lineTable[4] = '{1'b1, 'hF0, 'h40, 24, 3, 18, 24, opOtherRead, 16'h1234};
		lineTable[5] = '{1'b0, 'h20, 'hF0, 24, 4, 0, 3, opKickRead, `WDOG_KICK_ADDR};
		lineTable[6] = '{1'b1, 'h00, 'h40, 24, 5, 0, 0, opPalRead, 16'h4A5C};
		cycleLimit = testLength() + 100;
		repeat (10) nextEdge();
		reset <= 1'b0;
		settle(1'b0, '0);
		checkPaletteAddr(paletteAddr, '0, "reset");
		checkAck(1'b0);
		checkReset(cpuReset, 1'b0);
		for (k = 0; k < lineCount; k++) begin
			applyLine(k);
		end
		watchdogRun();
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

/* hdl/pixelMixer.sv */
//*********************************************************************
// Pixel mixer top level
// Two sprite line buffers, display select, palette mux, host port
//*********************************************************************

`timescale 1ns/1ns

module pixelMixer import neoVideoPkg::*; (
	input  logic         CLK_1HB,
	input  logic         reset,
	// Line control, 0 shows buffer A and draws buffer B
	input  logic         lineSel,
	input  logic         drawLoad,
	input  lbAddr_t      drawStart,
	input  logic         drawStep,
	input  pixelColor_t  spriteColor,
	input  spritePal_t   spritePal,
	input  logic         showLoad,
	input  lbAddr_t      showStart,
	input  logic         showStep,
	// Fix layer pixel
	input  pixelColor_t  fixColor,
	input  fixPal_t      fixPal,
	input  logic         hblank,
	// Host bus
	input  logic         wbCyc,
	input  logic         wbStb,
	input  logic         wbWe,
	input  wbAddr_t      wbAdr,
	input  wbData_t      wbDatW,
	output logic         wbAck,
	output wbData_t      wbDatR,
	output paletteAddr_t paletteAddr,
	output logic         cpuReset
);

	logic         loadA, stepA, loadB, stepB;
	lbAddr_t      startA, startB;
	paletteAddr_t pixelA, pixelB;
	paletteAddr_t spritePixel;
	logic         cpuPalSel;
	paletteAddr_t cpuPalAddr;

	// Buffer role taken at the read, follows the pixel to the mux
	logic         showSelQ;

	// Role routing, the drawn buffer gets the draw controls
	assign loadA  = lineSel ? drawLoad  : showLoad;
	assign startA = lineSel ? drawStart : showStart;
	assign stepA  = lineSel ? drawStep  : showStep;
	assign loadB  = lineSel ? showLoad  : drawLoad;
	assign startB = lineSel ? showStart : drawStart;
	assign stepB  = lineSel ? showStep  : drawStep;

	lineBuffer bufA (
		.CLK_1HB(CLK_1HB), .reset(reset), .displayRole(!lineSel),
		.load(loadA), .startAddr(startA), .step(stepA),
		.color(spriteColor), .pal(spritePal), .pixelOut(pixelA)
	);

	lineBuffer bufB (
		.CLK_1HB(CLK_1HB), .reset(reset), .displayRole(lineSel),
		.load(loadB), .startAddr(startB), .step(stepB),
		.color(spriteColor), .pal(spritePal), .pixelOut(pixelB)
	);

	always_ff @(posedge CLK_1HB) begin
		if (reset) begin
			showSelQ <= 1'b0;
		end else begin
			showSelQ <= lineSel;
		end
	end

	// Output of the buffer that was shown
	assign spritePixel = showSelQ ? pixelB : pixelA;

	paletteAddrMux palMux (
		.CLK_1HB(CLK_1HB), .reset(reset), .spritePixel(spritePixel),
		.fixColor(fixColor), .fixPal(fixPal), .hblank(hblank),
		.cpuPalSel(cpuPalSel), .cpuPalAddr(cpuPalAddr), .paletteAddr(paletteAddr)
	);

	hostBusPort hostPort (
		.CLK_1HB(CLK_1HB), .reset(reset), .wbCyc(wbCyc), .wbStb(wbStb),
		.wbWe(wbWe), .wbAdr(wbAdr), .wbDatW(wbDatW), .wbAck(wbAck),
		.wbDatR(wbDatR), .cpuPalSel(cpuPalSel), .cpuPalAddr(cpuPalAddr),
		.cpuReset(cpuReset)
	);

endmodule

/* hdl/hostBusPort.sv */
//*********************************************************************
// Host bus port
// Wishbone classic slave, palette window decode and watchdog
//*********************************************************************

`timescale 1ns/1ns

`include "pixelMixer_cfg.svh"

module hostBusPort import neoVideoPkg::*; (
	input  logic         CLK_1HB,
	input  logic         reset,
	input  logic         wbCyc,
	input  logic         wbStb,
	input  logic         wbWe,
	input  wbAddr_t      wbAdr,
	input  wbData_t      wbDatW,
	output logic         wbAck,
	output wbData_t      wbDatR,
	// Palette window hit, valid in the ack cycle
	output logic         cpuPalSel,
	output paletteAddr_t cpuPalAddr,
	output logic         cpuReset
);

	localparam int cntBits   = $clog2(`WDOG_TIMEOUT + 1);
	localparam int pulseBits = $clog2(`WDOG_RESET_LEN + 1);

	logic                 busReq;
	logic                 palHit;
	logic                 kickHit;
	logic                 kickWrite;
	logic [cntBits-1:0]   wdogCount;
	logic [pulseBits-1:0] pulseCount;
	logic [cntBits-1:0]   remaining;

	// New request, the ack cycle itself is not sampled again
	assign busReq    = wbCyc && wbStb && !wbAck;
	assign palHit    = (wbAdr[15:12] == `PAL_WIN_BASE);
	assign kickHit   = (wbAdr == `WDOG_KICK_ADDR);
	assign kickWrite = busReq && wbWe && kickHit;
	assign remaining = cntBits'(`WDOG_TIMEOUT) - wdogCount;

	// Ack and window select, one cycle after the request
	always_ff @(posedge CLK_1HB) begin
		if (reset) begin
			wbAck     <= 1'b0;
			cpuPalSel <= 1'b0;
			wbDatR    <= '0;
		end else begin
			wbAck     <= busReq;
			cpuPalSel <= busReq && palHit;
			// Only the kick register reads back
			if (busReq && !wbWe && kickHit) begin
				wbDatR <= wbData_t'(remaining);
			end else begin
				wbDatR <= '0;
			end
		end
	end

	// Low address bits go straight to the palette bus
	always_ff @(posedge CLK_1HB) begin
		if (busReq) begin
			cpuPalAddr <= wbAdr[11:0];
		end
	end

	// Watchdog
	// Counts up until a kick or the timeout, then holds during the pulse
	always_ff @(posedge CLK_1HB) begin
		if (reset) begin
			wdogCount  <= '0;
			pulseCount <= '0;
			cpuReset   <= 1'b0;
		end else if (cpuReset) begin
			if (pulseCount == '0) begin
				cpuReset  <= 1'b0;
				wdogCount <= '0;
			end else begin
				pulseCount <= pulseCount - 1'b1;
			end
		end else if (kickWrite) begin
			wdogCount <= '0;
		end else if (wdogCount == cntBits'(`WDOG_TIMEOUT - 1)) begin
			// Timeout, start the CPU reset pulse
			cpuReset   <= 1'b1;
			pulseCount <= pulseBits'(`WDOG_RESET_LEN - 1);
		end else begin
			wdogCount <= wdogCount + 1'b1;
		end
	end

	// Single cycle ack, a stuck ack would repeat the access
	hbAckSingle: assert property (
		@(posedge CLK_1HB) disable iff (reset)
		wbAck |=> !wbAck
	) else $error("hostBusPort ack held for two cycles");

	hbWriteDataKnown: assert property (
		@(posedge CLK_1HB) disable iff (reset)
		(wbCyc && wbStb && wbWe) |-> !$isunknown(wbDatW)
	) else $error("hostBusPort write with unknown data");

endmodule

/* hdl/paletteAddrMux.sv */
//*********************************************************************
// Palette address mux
// Fix latch, fix over sprite priority, blanking and CPU override
//*********************************************************************

`timescale 1ns/1ns

module paletteAddrMux import neoVideoPkg::*; (
	input  logic         CLK_1HB,
	input  logic         reset,
	// Line buffer read, one cycle old
	input  paletteAddr_t spritePixel,
	input  pixelColor_t  fixColor,
	input  fixPal_t      fixPal,
	input  logic         hblank,
	// CPU palette window access
	input  logic         cpuPalSel,
	input  paletteAddr_t cpuPalAddr,
	output paletteAddr_t paletteAddr
);

	// Fix pixel and blank, delayed to meet the buffer read
	pixelColor_t  fixColorQ;
	fixPal_t      fixPalQ;
	logic         hblankQ;

	// Fix pixel as a palette entry
	paletteAddr_t fixEntry;
	logic         fixOpaque;

	// Selected video address before the output register
	paletteAddr_t videoSel;
	paletteAddr_t videoAddr;

	// Fix pixel stage
	always_ff @(posedge CLK_1HB) begin
		fixColorQ <= fixColor;
		fixPalQ   <= fixPal;
	end

	// Blank flag
	always_ff @(posedge CLK_1HB) begin
		if (reset) begin
			hblankQ <= 1'b1;
		end else begin
			hblankQ <= hblank;
		end
	end

	// Fix palettes sit in the first 256 palette entries
	assign fixEntry  = {4'h0, fixPalQ, fixColorQ};
	assign fixOpaque = (fixColorQ != '0);

	// Priority for the video side
	// Blank first, then an opaque fix pixel, then the sprites
	always_comb begin
		if (hblankQ) begin
			videoSel = '0;
		end else if (fixOpaque) begin
			videoSel = fixEntry;
		end else begin
			videoSel = spritePixel;
		end
	end

	// Output register of the video path
	always_ff @(posedge CLK_1HB) begin
		if (reset) begin
			videoAddr <= '0;
		end else begin
			videoAddr <= videoSel;
		end
	end

	// CPU takes the palette bus, video keeps running behind it
	assign paletteAddr = cpuPalSel ? cpuPalAddr : videoAddr;

	// An unknown address on the palette bus would hit a random entry
	palCpuAddrKnown: assert property (
		@(posedge CLK_1HB) disable iff (reset)
		cpuPalSel |-> !$isunknown(cpuPalAddr)
	) else $error("paletteAddrMux CPU address unknown in window access");

endmodule

/* hdl/lineBuffer.sv */
//*********************************************************************
// Sprite line buffer
// Entry memory, address counter, draw writes, clear-on-read display
//*********************************************************************

`timescale 1ns/1ns

`include "pixelMixer_cfg.svh"

module lineBuffer import neoVideoPkg::*; (
	input  logic         CLK_1HB,
	input  logic         reset,
	// High while this buffer is being shown
	input  logic         displayRole,
	input  logic         load,
	input  lbAddr_t      startAddr,
	input  logic         step,
	// Sprite pixel to draw
	input  pixelColor_t  color,
	input  spritePal_t   pal,
	// Entry read in the display role
	output paletteAddr_t pixelOut
);

	// One entry per pixel of the line
	localparam int depth = 1 << `LB_ADDR_BITS;

	paletteAddr_t entries [depth];
	lbAddr_t      addrCnt;

	// Sprite pixel as stored
	paletteAddr_t drawEntry;

	// Transparent pixels never touch the memory
	logic         drawOpaque;

	// Draw side write strobe
	logic         drawWrite;

	// Display side read and clear strobe
	logic         showRead;

	assign drawEntry  = {pal, color};
	assign drawOpaque = (color != '0);
	assign drawWrite  = step && !displayRole && drawOpaque;
	assign showRead   = step && displayRole;

	// Address counter
	// Load sets the start of the sprite or of the visible line
	// Each step moves one pixel to the right
	always_ff @(posedge CLK_1HB) begin
		if (reset) begin
			addrCnt <= '0;
		end else if (load) begin
			addrCnt <= startAddr;
		end else if (step) begin
			addrCnt <= addrCnt + 1'b1;
		end
	end

	// Entry memory
	// Draw role writes palette and color of opaque pixels
	// Display role reads the entry and leaves zero behind
	// so that the buffer is blank when it is drawn again
	always_ff @(posedge CLK_1HB) begin
		if (drawWrite) begin
			entries[addrCnt] <= drawEntry;
		end
		if (showRead) begin
			entries[addrCnt] <= '0;
		end
	end

	// Read register
	// Holds the last shown pixel between steps
	always_ff @(posedge CLK_1HB) begin
		if (showRead) begin
			pixelOut <= entries[addrCnt];
		end
	end

	// Counter would move twice or jump on the same edge
	lbLoadStepExclusive: assert property (
		@(posedge CLK_1HB) disable iff (reset)
		!(load && step)
	) else $error("lineBuffer load and step high together");

	// Unknown color would corrupt the entry of the next line
	lbDrawColorKnown: assert property (
		@(posedge CLK_1HB) disable iff (reset)
		(step && !displayRole) |-> !$isunknown(color)
	) else $error("lineBuffer draw step with unknown color");

endmodule

/* hdl/neoVideoPkg.sv */
//*********************************************************************
// Shared video types
// Pixel colors, palette numbers, palette and host bus words
//*********************************************************************

`include "pixelMixer_cfg.svh"

package neoVideoPkg;

	// Color index inside a palette
	// Zero is the transparent color
	typedef logic [3:0] pixelColor_t;

	// Sprite palette number
	typedef logic [7:0] spritePal_t;

	// Fix layer palette number, only the low 16 palettes
	typedef logic [3:0] fixPal_t;

	// Palette RAM address
	// Palette number in the upper bits, color in the low nibble
	typedef logic [11:0] paletteAddr_t;

	// Line buffer entry address
	typedef logic [`LB_ADDR_BITS-1:0] lbAddr_t;

	// Host bus word address and data
	typedef logic [15:0] wbAddr_t;
	typedef logic [15:0] wbData_t;

endpackage

/* include/pixelMixer_cfg.svh */
//*********************************************************************
// Build constants for the pixel mixer
// Line buffer size, host address map and watchdog timing
//*********************************************************************

`ifndef PIXEL_MIXER_CFG_SVH
`define PIXEL_MIXER_CFG_SVH

// Line buffer address width, 256 entries
`define LB_ADDR_BITS 8

// Top 4 host address bits that open the palette window
`define PAL_WIN_BASE 4'h4

// Host word address of the watchdog kick register
`define WDOG_KICK_ADDR 16'h3C00

// Cycles without a kick before the CPU reset fires
`define WDOG_TIMEOUT 512

// Length of the CPU reset pulse in cycles
`define WDOG_RESET_LEN 8

`endif
